// ==== hw/mips_pkg.sv ====
package mips_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// data word or instruction
	typedef logic [31:0] word_t;
	// register index, r0 reads as zero
	typedef logic [4:0] reg_idx_t;
	// instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	// alu selector
	typedef logic [2:0] alu_op_t;
	// word addresses of the two memories
	typedef logic [7:0] imem_adr_t;
	typedef logic [7:0] dmem_adr_t;
	// wishbone word address, one bit more than a memory address
	typedef logic [8:0] wb_adr_t;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_HALT  = 6'h3f;

	// r-type function codes
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2a;

	// alu operations
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_SLT = 3'd4;

	// memory depths in words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;

	// wishbone map: bit set means data memory
	localparam int WB_DMEM_BIT = 8;

	// all zeros, decodes as a write to r0
	localparam word_t NOP_WORD = 32'h0000_0000;

	// core run state, held in fetch
	typedef enum logic [1:0] {
		RS_IDLE,
		RS_RUN,
		RS_HALTED
	} run_state_t;

endpackage

// ==== hw/mips_fetch.sv ====
`timescale 1ns/1ps

module mips_fetch (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  mips_pkg::wb_adr_t   wb_adr,
	input  mips_pkg::word_t     wb_dat_w,
	output mips_pkg::word_t     wb_dat_r,
	output logic                wb_ack,
	output logic                dbg_we,
	output mips_pkg::dmem_adr_t dbg_adr,
	output mips_pkg::word_t     dbg_wdata,
	input  mips_pkg::word_t     dbg_rdata,
	input  logic                br_taken,
	input  mips_pkg::imem_adr_t br_target,
	input  logic                halt_req,
	output mips_pkg::word_t     f_instr,
	output mips_pkg::imem_adr_t f_pc_next,
	output mips_pkg::imem_adr_t pc,
	output logic                halted
);

	mips_pkg::run_state_t state;
	mips_pkg::word_t      imem [mips_pkg::IMEM_WORDS];
	mips_pkg::word_t      fetch_word;
	mips_pkg::imem_adr_t  pc_inc;
	logic                 fetch_stop;
	logic                 wb_req;
	logic                 wb_open;
	logic                 to_dmem;

	//////////////////////////////
	// wishbone slave
	//////////////////////////////

	// new request, not the one being acked
	assign wb_req  = wb_cyc && wb_stb && !wb_ack;
	// memories reachable only while the core is stopped
	assign wb_open = (state != mips_pkg::RS_RUN);
	assign to_dmem = wb_adr[mips_pkg::WB_DMEM_BIT];

	// data memory lives in result
	assign dbg_we    = wb_ack && wb_we && to_dmem && wb_open;
	assign dbg_adr   = wb_adr[7:0];
	assign dbg_wdata = wb_dat_w;

	// one-cycle ack after the request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_req;
	end

	// read data ready with ack, imem write on the ack cycle
	always_ff @(posedge clk) begin
		if (wb_req)
			wb_dat_r <= !wb_open ? '0 : (to_dmem ? dbg_rdata : imem[wb_adr[7:0]]);
		if (wb_ack && wb_we && !to_dmem && wb_open)
			imem[wb_adr[7:0]] <= wb_dat_w;
	end

	//////////////////////////////
	// run state
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mips_pkg::RS_IDLE;
		end else if (!run) begin
			state <= mips_pkg::RS_IDLE;
		end else begin
			case (state)
				mips_pkg::RS_IDLE: state <= mips_pkg::RS_RUN;
				mips_pkg::RS_RUN:  if (halt_req) state <= mips_pkg::RS_HALTED;
				default:           state <= state;
			endcase
		end
	end

	assign halted = (state == mips_pkg::RS_HALTED);

	// fetch path, combinational imem read
	assign fetch_word = imem[pc];
	assign pc_inc     = pc + 8'd1;

	// pc and the instruction half of the fetch/decode register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= '0;
			f_instr    <= mips_pkg::NOP_WORD;
			fetch_stop <= 1'b0;
		end else if (!run || state == mips_pkg::RS_IDLE) begin
			pc         <= '0;
			f_instr    <= mips_pkg::NOP_WORD;
			fetch_stop <= 1'b0;
		end else if (state == mips_pkg::RS_RUN) begin
			if (br_taken) begin
				// redirect, kill the word in flight
				pc         <= br_target;
				f_instr    <= mips_pkg::NOP_WORD;
				fetch_stop <= 1'b0;
			end else if (fetch_stop) begin
				// halt already fetched, feed bubbles
				f_instr <= mips_pkg::NOP_WORD;
			end else begin
				pc         <= pc_inc;
				f_instr    <= fetch_word;
				fetch_stop <= (fetch_word[31:26] == mips_pkg::OP_HALT);
			end
		end
	end

	// pc+1 rides along for beq targets
	always_ff @(posedge clk) begin
		if (run && state == mips_pkg::RS_RUN)
			f_pc_next <= pc_inc;
	end

endmodule

// ==== hw/mips_decode.sv ====
`timescale 1ns/1ps

module mips_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                stall_all,
	input  mips_pkg::word_t     f_instr,
	input  mips_pkg::imem_adr_t f_pc_next,
	input  logic                flush,
	input  logic                wb_en,
	input  mips_pkg::reg_idx_t  wb_dest,
	input  mips_pkg::word_t     wb_data,
	output mips_pkg::word_t     d_rs_val,
	output mips_pkg::word_t     d_rt_val,
	output mips_pkg::word_t     d_imm,
	output mips_pkg::reg_idx_t  d_rs,
	output mips_pkg::reg_idx_t  d_rt,
	output mips_pkg::reg_idx_t  d_dest,
	output mips_pkg::alu_op_t   d_alu_op,
	output logic                d_use_imm,
	output logic                d_reg_write,
	output logic                d_mem_read,
	output logic                d_mem_write,
	output logic                d_branch,
	output logic                d_halt,
	output mips_pkg::imem_adr_t d_pc_next
);

	mips_pkg::opcode_t  opcode;
	mips_pkg::funct_t   funct;
	mips_pkg::reg_idx_t rs;
	mips_pkg::reg_idx_t rt;
	mips_pkg::reg_idx_t rd;
	mips_pkg::word_t    imm_sext;
	mips_pkg::word_t    rs_val;
	mips_pkg::word_t    rt_val;
	mips_pkg::word_t    regs [32];

	// decoded controls before the register
	mips_pkg::reg_idx_t c_dest;
	mips_pkg::alu_op_t  c_alu_op;
	logic               c_use_imm;
	logic               c_reg_write;
	logic               c_mem_read;
	logic               c_mem_write;
	logic               c_branch;
	logic               c_halt;

	// field split
	assign opcode   = f_instr[31:26];
	assign rs       = f_instr[25:21];
	assign rt       = f_instr[20:16];
	assign rd       = f_instr[15:11];
	assign funct    = f_instr[5:0];
	assign imm_sext = {{16{f_instr[15]}}, f_instr[15:0]};

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		c_dest      = rt;
		c_alu_op    = mips_pkg::ALU_ADD;
		c_use_imm   = 1'b0;
		c_reg_write = 1'b0;
		c_mem_read  = 1'b0;
		c_mem_write = 1'b0;
		c_branch    = 1'b0;
		c_halt      = 1'b0;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				c_dest      = rd;
				c_reg_write = 1'b1;
				// unknown funct falls back to add
				// so the all-zero nop lands on r0
				case (funct)
					mips_pkg::FN_SUBU: c_alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  c_alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   c_alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT:  c_alu_op = mips_pkg::ALU_SLT;
					default:           c_alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			mips_pkg::OP_ADDI: begin
				c_use_imm   = 1'b1;
				c_reg_write = 1'b1;
			end
			mips_pkg::OP_LW: begin
				c_use_imm   = 1'b1;
				c_reg_write = 1'b1;
				c_mem_read  = 1'b1;
			end
			mips_pkg::OP_SW: begin
				c_use_imm   = 1'b1;
				c_mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				c_alu_op = mips_pkg::ALU_SUB;
				c_branch = 1'b1;
			end
			mips_pkg::OP_HALT: c_halt = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////
	// register file
	//////////////////////////////

	// r0 stays unwritten
	always_ff @(posedge clk) begin
		if (wb_en && wb_dest != '0)
			regs[wb_dest] <= wb_data;
	end

	// write-through so the result stage never needs a stall
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (wb_en && wb_dest == idx)
			return wb_data;
		else
			return regs[idx];
	endfunction

	always_comb begin
		rs_val = read_port(rs);
		rt_val = read_port(rt);
	end

	// control half of the decode/execute register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_reg_write <= 1'b0;
			d_mem_read  <= 1'b0;
			d_mem_write <= 1'b0;
			d_branch    <= 1'b0;
			d_halt      <= 1'b0;
		end else if (!run || flush) begin
			d_reg_write <= 1'b0;
			d_mem_read  <= 1'b0;
			d_mem_write <= 1'b0;
			d_branch    <= 1'b0;
			d_halt      <= 1'b0;
		end else if (!stall_all) begin
			d_reg_write <= c_reg_write;
			d_mem_read  <= c_mem_read;
			d_mem_write <= c_mem_write;
			d_branch    <= c_branch;
			d_halt      <= c_halt;
		end
	end

	// payload half
	always_ff @(posedge clk) begin
		if (!stall_all) begin
			d_rs_val  <= rs_val;
			d_rt_val  <= rt_val;
			d_imm     <= imm_sext;
			d_rs      <= rs;
			d_rt      <= rt;
			d_dest    <= c_dest;
			d_alu_op  <= c_alu_op;
			d_use_imm <= c_use_imm;
			d_pc_next <= f_pc_next;
		end
	end

endmodule

// ==== hw/mips_execute.sv ====
`timescale 1ns/1ps

module mips_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                stall_all,
	input  mips_pkg::word_t     d_rs_val,
	input  mips_pkg::word_t     d_rt_val,
	input  mips_pkg::word_t     d_imm,
	input  mips_pkg::reg_idx_t  d_rs,
	input  mips_pkg::reg_idx_t  d_rt,
	input  mips_pkg::reg_idx_t  d_dest,
	input  mips_pkg::alu_op_t   d_alu_op,
	input  logic                d_use_imm,
	input  logic                d_reg_write,
	input  logic                d_mem_read,
	input  logic                d_mem_write,
	input  logic                d_branch,
	input  logic                d_halt,
	input  mips_pkg::imem_adr_t d_pc_next,
	input  logic                wb_en,
	input  mips_pkg::reg_idx_t  wb_dest,
	input  mips_pkg::word_t     wb_data,
	output logic                br_taken,
	output mips_pkg::imem_adr_t br_target,
	output mips_pkg::word_t     e_alu_result,
	output mips_pkg::word_t     e_store_data,
	output mips_pkg::reg_idx_t  e_dest,
	output logic                e_reg_write,
	output logic                e_mem_read,
	output logic                e_mem_write,
	output logic                e_halt
);

	mips_pkg::word_t op_a;
	mips_pkg::word_t fwd_b;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_out;

	// take the result stage value when it writes the same non-zero register
	function automatic mips_pkg::word_t forward(input mips_pkg::reg_idx_t idx,
			input mips_pkg::word_t reg_val);
		if (wb_en && wb_dest != '0 && wb_dest == idx)
			return wb_data;
		else
			return reg_val;
	endfunction

	always_comb begin
		op_a  = forward(d_rs, d_rs_val);
		fwd_b = forward(d_rt, d_rt_val);
		op_b  = d_use_imm ? d_imm : fwd_b;
	end

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (d_alu_op)
			mips_pkg::ALU_SUB: alu_out = op_a - op_b;
			mips_pkg::ALU_AND: alu_out = op_a & op_b;
			mips_pkg::ALU_OR:  alu_out = op_a | op_b;
			// signed compare
			mips_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			default:           alu_out = op_a + op_b;
		endcase
	end

	// beq on forwarded operands
	assign br_taken  = run && !stall_all && d_branch && (op_a == fwd_b);
	// word offset from pc+1 wrapping in the 8-bit space
	assign br_target = d_pc_next + d_imm[7:0];

	// control half of the execute/result register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_reg_write <= 1'b0;
			e_mem_read  <= 1'b0;
			e_mem_write <= 1'b0;
			e_halt      <= 1'b0;
		end else if (!run || br_taken) begin
			e_reg_write <= 1'b0;
			e_mem_read  <= 1'b0;
			e_mem_write <= 1'b0;
			e_halt      <= 1'b0;
		end else if (!stall_all) begin
			e_reg_write <= d_reg_write;
			e_mem_read  <= d_mem_read;
			e_mem_write <= d_mem_write;
			e_halt      <= d_halt;
		end
	end

	// payload half with the forwarded rt as store data
	always_ff @(posedge clk) begin
		if (!stall_all) begin
			e_alu_result <= alu_out;
			e_store_data <= fwd_b;
			e_dest       <= d_dest;
		end
	end

endmodule

// ==== hw/mips_result.sv ====
`timescale 1ns/1ps

module mips_result (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  mips_pkg::word_t     e_alu_result,
	input  mips_pkg::word_t     e_store_data,
	input  mips_pkg::reg_idx_t  e_dest,
	input  logic                e_reg_write,
	input  logic                e_mem_read,
	input  logic                e_mem_write,
	input  logic                e_halt,
	input  logic                dbg_we,
	input  mips_pkg::dmem_adr_t dbg_adr,
	input  mips_pkg::word_t     dbg_wdata,
	output mips_pkg::word_t     dbg_rdata,
	output logic                wb_en,
	output mips_pkg::reg_idx_t  wb_dest,
	output mips_pkg::word_t     wb_data,
	output logic                halt_req
);

	mips_pkg::word_t     dmem [mips_pkg::DMEM_WORDS];
	mips_pkg::dmem_adr_t mem_adr;
	mips_pkg::word_t     load_word;

	//////////////////////////////
	// data memory
	//////////////////////////////

	// byte address to word index
	assign mem_adr = e_alu_result[9:2];

	// pipeline store wins over the debug port
	// debug writes only come in while the core is stopped
	always_ff @(posedge clk) begin
		if (run && e_mem_write)
			dmem[mem_adr] <= e_store_data;
		else if (dbg_we)
			dmem[dbg_adr] <= dbg_wdata;
	end

	// both read ports combinational
	assign load_word = dmem[mem_adr];
	assign dbg_rdata = dmem[dbg_adr];

	// writeback select
	assign wb_en   = e_reg_write;
	assign wb_dest = e_dest;
	assign wb_data = e_mem_read ? load_word : e_alu_result;

	// raised while the halt sits in this stage
	assign halt_req = e_halt;

endmodule

// ==== hw/mips_top.sv ====
`timescale 1ns/1ps

module mips_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  mips_pkg::wb_adr_t   wb_adr,
	input  mips_pkg::word_t     wb_dat_w,
	output mips_pkg::word_t     wb_dat_r,
	output logic                wb_ack,
	output mips_pkg::imem_adr_t pc,
	output logic                halted
);

	// debug path to data memory
	logic                dbg_we;
	mips_pkg::dmem_adr_t dbg_adr;
	mips_pkg::word_t     dbg_wdata;
	mips_pkg::word_t     dbg_rdata;

	// fetch to decode
	mips_pkg::word_t     f_instr;
	mips_pkg::imem_adr_t f_pc_next;

	// decode to execute
	mips_pkg::word_t     d_rs_val;
	mips_pkg::word_t     d_rt_val;
	mips_pkg::word_t     d_imm;
	mips_pkg::reg_idx_t  d_rs;
	mips_pkg::reg_idx_t  d_rt;
	mips_pkg::reg_idx_t  d_dest;
	mips_pkg::alu_op_t   d_alu_op;
	logic                d_use_imm;
	logic                d_reg_write;
	logic                d_mem_read;
	logic                d_mem_write;
	logic                d_branch;
	logic                d_halt;
	mips_pkg::imem_adr_t d_pc_next;

	// execute to result
	mips_pkg::word_t     e_alu_result;
	mips_pkg::word_t     e_store_data;
	mips_pkg::reg_idx_t  e_dest;
	logic                e_reg_write;
	logic                e_mem_read;
	logic                e_mem_write;
	logic                e_halt;

	// feedback paths
	logic                br_taken;
	mips_pkg::imem_adr_t br_target;
	logic                wb_en;
	mips_pkg::reg_idx_t  wb_dest;
	mips_pkg::word_t     wb_data;
	logic                halt_req;

	//////////////////////////////
	// stages
	//////////////////////////////

	mips_fetch u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.dbg_we    (dbg_we),
		.dbg_adr   (dbg_adr),
		.dbg_wdata (dbg_wdata),
		.dbg_rdata (dbg_rdata),
		.br_taken  (br_taken),
		.br_target (br_target),
		.halt_req  (halt_req),
		.f_instr   (f_instr),
		.f_pc_next (f_pc_next),
		.pc        (pc),
		.halted    (halted)
	);

	// halted freezes decode and execute
	mips_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.stall_all   (halted),
		.f_instr     (f_instr),
		.f_pc_next   (f_pc_next),
		.flush       (br_taken),
		.wb_en       (wb_en),
		.wb_dest     (wb_dest),
		.wb_data     (wb_data),
		.d_rs_val    (d_rs_val),
		.d_rt_val    (d_rt_val),
		.d_imm       (d_imm),
		.d_rs        (d_rs),
		.d_rt        (d_rt),
		.d_dest      (d_dest),
		.d_alu_op    (d_alu_op),
		.d_use_imm   (d_use_imm),
		.d_reg_write (d_reg_write),
		.d_mem_read  (d_mem_read),
		.d_mem_write (d_mem_write),
		.d_branch    (d_branch),
		.d_halt      (d_halt),
		.d_pc_next   (d_pc_next)
	);

	mips_execute u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.stall_all    (halted),
		.d_rs_val     (d_rs_val),
		.d_rt_val     (d_rt_val),
		.d_imm        (d_imm),
		.d_rs         (d_rs),
		.d_rt         (d_rt),
		.d_dest       (d_dest),
		.d_alu_op     (d_alu_op),
		.d_use_imm    (d_use_imm),
		.d_reg_write  (d_reg_write),
		.d_mem_read   (d_mem_read),
		.d_mem_write  (d_mem_write),
		.d_branch     (d_branch),
		.d_halt       (d_halt),
		.d_pc_next    (d_pc_next),
		.wb_en        (wb_en),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.br_taken     (br_taken),
		.br_target    (br_target),
		.e_alu_result (e_alu_result),
		.e_store_data (e_store_data),
		.e_dest       (e_dest),
		.e_reg_write  (e_reg_write),
		.e_mem_read   (e_mem_read),
		.e_mem_write  (e_mem_write),
		.e_halt       (e_halt)
	);

	mips_result u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.e_alu_result (e_alu_result),
		.e_store_data (e_store_data),
		.e_dest       (e_dest),
		.e_reg_write  (e_reg_write),
		.e_mem_read   (e_mem_read),
		.e_mem_write  (e_mem_write),
		.e_halt       (e_halt),
		.dbg_we       (dbg_we),
		.dbg_adr      (dbg_adr),
		.dbg_wdata    (dbg_wdata),
		.dbg_rdata    (dbg_rdata),
		.wb_en        (wb_en),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.halt_req     (halt_req)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset low across the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== test/tb_mips.sv ====
`timescale 1ns/1ps

module tb_mips;

	// cycle budget per test, run bounded by the sum
	localparam int TEST_CYCLES = 400;
	localparam int NUM_TESTS   = 6;
	localparam int CYCLE_LIMIT = TEST_CYCLES * NUM_TESTS;
	localparam int ACK_WAIT    = 8;
	localparam int MODEL_STEPS = 200;

	logic                clk;
	logic                rst_n;
	logic                run;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	mips_pkg::wb_adr_t   wb_adr;
	mips_pkg::word_t     wb_dat_w;
	mips_pkg::word_t     wb_dat_r;
	logic                wb_ack;
	mips_pkg::imem_adr_t pc;
	logic                halted;

	// program under test, also the model's instruction memory
	mips_pkg::word_t     prog [$];
	// reference model state
	mips_pkg::word_t     model_regs [32];
	mips_pkg::word_t     model_dmem [256];
	mips_pkg::imem_adr_t model_halt_pc;

	mips_pkg::word_t     lcg_state;
	int                  cycles;
	int                  errors;
	int                  pass_count;
	int                  fail_count;
	int                  test_err_base;
	string               test_name;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.pc       (pc),
		.halted   (halted)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	// numerical recipes constants
	function automatic mips_pkg::word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input string what, input mips_pkg::word_t exp,
			input mips_pkg::word_t act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string what, input mips_pkg::imem_adr_t exp,
			input mips_pkg::imem_adr_t act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = errors;
	endtask

	task automatic end_test();
		if (errors == test_err_base) begin
			pass_count++;
			$display("test %s: passed", test_name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", test_name, errors - test_err_base);
		end
	endtask

	//////////////////////////////
	// wishbone master
	//////////////////////////////

	// called on a falling edge, returns on one
	task automatic wb_xfer(input logic we, input mips_pkg::wb_adr_t adr,
			input mips_pkg::word_t wdata, output mips_pkg::word_t rdata);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < ACK_WAIT);
		if (!wb_ack) begin
			$display("%s: no wb_ack for address %h", test_name, adr);
			errors++;
		end
		rdata = wb_dat_r;
		// address, data and we stay put through the write edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
		if (wb_ack) begin
			$display("%s: wb_ack lasted more than one cycle at address %h", test_name, adr);
			errors++;
		end
	endtask

	task automatic wb_write(input mips_pkg::wb_adr_t adr, input mips_pkg::word_t data);
		mips_pkg::word_t ignored_rdata;
		wb_xfer(1'b1, adr, data, ignored_rdata);
	endtask

	task automatic wb_read(input mips_pkg::wb_adr_t adr, output mips_pkg::word_t data);
		wb_xfer(1'b0, adr, '0, data);
	endtask

	// preload a data word into the DUT and the model alike
	task automatic dmem_put(input mips_pkg::dmem_adr_t adr, input mips_pkg::word_t data);
		wb_write({1'b1, adr}, data);
		model_dmem[adr] = data;
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++)
			wb_write({1'b0, 8'(i)}, prog[i]);
	endtask

	// bounded wait for halted, run stays high so halted state holds
	task automatic run_until_halt();
		int waited;
		run    = 1'b1;
		waited = 0;
		while (!halted && waited < TEST_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!halted) begin
			$display("%s: core did not halt within %0d cycles", test_name, TEST_CYCLES);
			errors++;
		end
	endtask

	task automatic stop_core();
		run = 1'b0;
		@(negedge clk);
	endtask

	//////////////////////////////
	// instruction encoding
	//////////////////////////////

	task automatic r_op(input mips_pkg::funct_t fn, input mips_pkg::reg_idx_t rd,
			input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt);
		prog.push_back({mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn});
	endtask

	// assembly order, op rt, rs, imm
	task automatic i_op(input mips_pkg::opcode_t op, input mips_pkg::reg_idx_t rt,
			input mips_pkg::reg_idx_t rs, input logic [15:0] imm);
		prog.push_back({op, rs, rt, imm});
	endtask

	task automatic halt_op();
		prog.push_back({mips_pkg::OP_HALT, 26'd0});
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic mips_pkg::word_t model_alu(input mips_pkg::funct_t fn,
			input mips_pkg::word_t a, input mips_pkg::word_t b);
		case (fn)
			mips_pkg::FN_SUBU: return a - b;
			mips_pkg::FN_AND:  return a & b;
			mips_pkg::FN_OR:   return a | b;
			// slt compares two's complement values
			mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:           return a + b;
		endcase
	endfunction

	task automatic reg_put(input mips_pkg::reg_idx_t idx, input mips_pkg::word_t val);
		if (idx != 5'd0)
			model_regs[idx] = val;
	endtask

	// sequential ISA execution, no pipeline
	task automatic model_run(output mips_pkg::imem_adr_t halt_pc);
		mips_pkg::imem_adr_t mpc;
		mips_pkg::word_t     ins;
		mips_pkg::word_t     a;
		mips_pkg::word_t     b;
		mips_pkg::word_t     imm;
		mips_pkg::word_t     ea;
		logic                done;
		int                  steps;
		mpc     = '0;
		halt_pc = '0;
		done    = 1'b0;
		steps   = 0;
		while (!done && steps < MODEL_STEPS) begin
			if (int'(mpc) < prog.size())
				ins = prog[mpc];
			else
				ins = mips_pkg::NOP_WORD;
			a   = model_regs[ins[25:21]];
			b   = model_regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			// byte address for loads and stores, sum for addi
			ea  = a + imm;
			mpc = mpc + 8'd1;
			case (ins[31:26])
				mips_pkg::OP_RTYPE: reg_put(ins[15:11], model_alu(ins[5:0], a, b));
				mips_pkg::OP_ADDI:  reg_put(ins[20:16], ea);
				mips_pkg::OP_LW:    reg_put(ins[20:16], model_dmem[ea[9:2]]);
				mips_pkg::OP_SW:    model_dmem[ea[9:2]] = b;
				// word offset from the next pc
				mips_pkg::OP_BEQ: begin
					if (a == b)
						mpc = mpc + imm[7:0];
				end
				mips_pkg::OP_HALT: begin
					halt_pc = mpc - 8'd1;
					done    = 1'b1;
				end
				default: ;
			endcase
			steps++;
		end
		if (!done) begin
			$display("%s: model never reached a halt", test_name);
			errors++;
		end
	endtask

	task automatic compare_dmem(input mips_pkg::dmem_adr_t first, input int count);
		mips_pkg::dmem_adr_t adr;
		mips_pkg::word_t     got;
		int                  i;
		for (i = 0; i < count; i++) begin
			adr = first + 8'(i);
			wb_read({1'b1, adr}, got);
			check_word($sformatf("dmem[%h]", adr), model_dmem[adr], got);
		end
	endtask

	// load, model, run, then check pc and the stored words
	task automatic run_program(input mips_pkg::dmem_adr_t first, input int count);
		load_program();
		model_run(model_halt_pc);
		run_until_halt();
		check_addr("pc at halt", model_halt_pc + 8'd1, pc);
		compare_dmem(first, count);
		stop_core();
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_memory_port();
		mips_pkg::word_t imem_vals [16];
		mips_pkg::word_t dmem_vals [16];
		mips_pkg::word_t got;
		int              i;
		begin_test("memory_port");
		check_addr("pc after reset", 8'h00, pc);
		if (halted || wb_ack) begin
			$display("%s: halted or wb_ack high after reset", test_name);
			errors++;
		end
		for (i = 0; i < 16; i++) begin
			imem_vals[i] = lcg_next();
			dmem_vals[i] = lcg_next();
			wb_write({1'b0, 8'h80 + 8'(i)}, imem_vals[i]);
			dmem_put(8'hc0 + 8'(i), dmem_vals[i]);
		end
		// read back after all writes so no address aliases another
		for (i = 0; i < 16; i++) begin
			wb_read({1'b0, 8'h80 + 8'(i)}, got);
			check_word($sformatf("imem[%h]", 8'h80 + 8'(i)), imem_vals[i], got);
			wb_read({1'b1, 8'hc0 + 8'(i)}, got);
			check_word($sformatf("dmem[%h]", 8'hc0 + 8'(i)), dmem_vals[i], got);
		end
		end_test();
	endtask

	task automatic test_alu_chain();
		begin_test("alu_chain");
		prog.delete();
		i_op(mips_pkg::OP_ADDI, 1, 0, 16'h1234);
		// negative immediate, sign extended
		i_op(mips_pkg::OP_ADDI, 2, 1, 16'he000);
		r_op(mips_pkg::FN_ADDU, 3, 2, 1);
		r_op(mips_pkg::FN_SUBU, 4, 3, 1);
		r_op(mips_pkg::FN_AND, 5, 4, 3);
		r_op(mips_pkg::FN_OR, 6, 5, 2);
		r_op(mips_pkg::FN_SLT, 7, 6, 5);
		// store data forwarded straight from the slt
		i_op(mips_pkg::OP_SW, 7, 0, 16'h0100);
		i_op(mips_pkg::OP_SW, 6, 0, 16'h0104);
		i_op(mips_pkg::OP_SW, 5, 0, 16'h0108);
		i_op(mips_pkg::OP_SW, 4, 0, 16'h010c);
		i_op(mips_pkg::OP_SW, 3, 0, 16'h0110);
		i_op(mips_pkg::OP_SW, 2, 0, 16'h0114);
		halt_op();
		run_program(8'h40, 6);
		end_test();
	endtask

	task automatic test_load_use();
		begin_test("load_use");
		prog.delete();
		i_op(mips_pkg::OP_ADDI, 1, 0, 16'h0055);
		i_op(mips_pkg::OP_ADDI, 2, 0, 16'h0aa0);
		i_op(mips_pkg::OP_SW, 1, 0, 16'h0120);
		i_op(mips_pkg::OP_LW, 3, 0, 16'h0120);
		// consumer right behind the load
		r_op(mips_pkg::FN_ADDU, 4, 3, 2);
		i_op(mips_pkg::OP_SW, 4, 0, 16'h0124);
		halt_op();
		run_program(8'h48, 2);
		end_test();
	endtask

	task automatic test_branches();
		begin_test("branches");
		prog.delete();
		i_op(mips_pkg::OP_ADDI, 1, 0, 16'h0003);
		i_op(mips_pkg::OP_ADDI, 3, 0, 16'h0011);
		i_op(mips_pkg::OP_SW, 3, 0, 16'h0140);
		i_op(mips_pkg::OP_ADDI, 2, 0, 16'h0003);
		// taken, compare operand forwarded from the addi above
		i_op(mips_pkg::OP_BEQ, 2, 1, 16'h0002);
		i_op(mips_pkg::OP_ADDI, 3, 0, 16'h0066);
		i_op(mips_pkg::OP_SW, 3, 0, 16'h0140);
		i_op(mips_pkg::OP_ADDI, 4, 0, 16'h0004);
		// not taken, 3 vs 4
		i_op(mips_pkg::OP_BEQ, 4, 1, 16'h0001);
		i_op(mips_pkg::OP_SW, 4, 0, 16'h0144);
		i_op(mips_pkg::OP_SW, 3, 0, 16'h0148);
		halt_op();
		run_program(8'h50, 3);
		end_test();
	endtask

	task automatic test_random_ops();
		mips_pkg::word_t rnd;
		int              round;
		int              i;
		begin_test("random_ops");
		for (round = 0; round < 2; round++) begin
			for (i = 0; i < 4; i++)
				dmem_put(8'h60 + 8'(i), lcg_next());
			rnd = lcg_next();
			prog.delete();
			i_op(mips_pkg::OP_LW, 1, 0, 16'h0180);
			i_op(mips_pkg::OP_LW, 2, 0, 16'h0184);
			i_op(mips_pkg::OP_LW, 3, 0, 16'h0188);
			i_op(mips_pkg::OP_LW, 4, 0, 16'h018c);
			r_op(mips_pkg::FN_ADDU, 5, 1, 2);
			r_op(mips_pkg::FN_SUBU, 6, 3, 4);
			r_op(mips_pkg::FN_AND, 7, 1, 3);
			r_op(mips_pkg::FN_OR, 8, 2, 4);
			r_op(mips_pkg::FN_SLT, 9, 1, 2);
			r_op(mips_pkg::FN_SLT, 10, 3, 4);
			i_op(mips_pkg::OP_ADDI, 11, 4, rnd[15:0]);
			// r5..r11 to words 64..6a
			for (i = 0; i < 7; i++)
				i_op(mips_pkg::OP_SW, 5'(5 + i), 0, 16'h0190 + 16'(4 * i));
			halt_op();
			run_program(8'h64, 7);
		end
		end_test();
	endtask

	task automatic test_halt_restart();
		int i;
		begin_test("halt_restart");
		prog.delete();
		i_op(mips_pkg::OP_ADDI, 1, 0, 16'h0015);
		i_op(mips_pkg::OP_ADDI, 2, 1, 16'h0015);
		r_op(mips_pkg::FN_ADDU, 3, 2, 1);
		i_op(mips_pkg::OP_SW, 3, 0, 16'h01c0);
		i_op(mips_pkg::OP_SW, 2, 0, 16'h01c4);
		halt_op();
		load_program();
		model_run(model_halt_pc);
		run_until_halt();
		// pc frozen one past the halt
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_addr("pc while halted", model_halt_pc + 8'd1, pc);
			if (!halted) begin
				$display("%s: halted dropped while run was high", test_name);
				errors++;
			end
		end
		compare_dmem(8'h70, 2);
		// wipe results in the DUT only, the rerun must rebuild them
		wb_write({1'b1, 8'h70}, '0);
		wb_write({1'b1, 8'h71}, '0);
		stop_core();
		check_addr("pc after run low", 8'h00, pc);
		run_until_halt();
		check_addr("pc after rerun", model_halt_pc + 8'd1, pc);
		compare_dmem(8'h70, 2);
		stop_core();
		end_test();
	endtask

	//////////////////////////////
	// run control
	//////////////////////////////

	// global watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int i;
		run        = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		lcg_state  = 32'h1788;
		cycles     = 0;
		errors     = 0;
		pass_count = 0;
		fail_count = 0;
		test_name  = "init";
		for (i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (i = 0; i < 256; i++)
			model_dmem[i] = '0;

		@(posedge rst_n);
		@(negedge clk);

		test_memory_port();
		test_alu_chain();
		test_load_use();
		test_branches();
		test_random_ops();
		test_halt_restart();

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_result.sv
hw/mips_top.sv
test/tb_clock.sv
test/tb_mips.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, decide from the log

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_mips -o tb_mips_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_mips_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi
exit 1
